// File: Makefile
TOP = microsequencer_tb

all: run

build:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: design/microsequencer.sv
`timescale 1ns/10ps
`default_nettype none

module microsequencer (
   input  wire                         clk,
   input  wire                         reset,
   input  wire useq_pkg::uinst_t       uinst,
   input  wire useq_pkg::disp_entry_t  disp,
   input  wire                         jcond,
   input  wire                         trap,
   input  wire useq_pkg::pc_t          spc_wdata,
   output wire useq_pkg::pc_t          pc,
   output wire                         fetch,
   output wire                         annul,
   output wire                         spc_drive,
   output wire useq_pkg::pc_t          spc_data,
   output wire useq_pkg::spc_ptr_t     spc_ptr
);
   import useq_pkg::*;

   seq_ctl_t ctl;
   pc_t      ret_pc;
   pc_t      spc_top;

   // Phase is left open here
   seq_control u_ctl (
      .clk       (clk),
      .reset     (reset),
      .uinst     (uinst),
      .disp      (disp),
      .jcond     (jcond),
      .trap      (trap),
      .ctl       (ctl),
      .spc_drive (spc_drive),
      .annul     (annul),
      .phase     ()
   );

   pc_select u_pc (
      .clk       (clk),
      .reset     (reset),
      .ctl       (ctl),
      .target    (ctl.target),
      .disp_addr (ctl.disp_addr),
      .spc_top   (spc_top),
      .pc        (pc),
      .ret_pc    (ret_pc)
   );

   spc_stack u_spc (
      .clk       (clk),
      .reset     (reset),
      .ctl       (ctl),
      .ret_pc    (ret_pc),
      .spc_wdata (spc_wdata),
      .spc_top   (spc_top),
      .spc_ptr   (spc_ptr)
   );

   assign fetch    = ctl.fetch;
   assign spc_data = spc_top;

endmodule

`default_nettype wire

// File: design/pc_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "useq_settings.svh"

module pc_select (
   input  wire                      clk,
   input  wire                      reset,
   input  wire useq_pkg::seq_ctl_t  ctl,
   input  wire useq_pkg::pc_t       target,
   input  wire useq_pkg::pc_t       disp_addr,
   input  wire useq_pkg::pc_t       spc_top,
   output useq_pkg::pc_t            pc,
   output useq_pkg::pc_t            ret_pc
);
   import useq_pkg::*;

   pc_t next_pc;

   // A call returns to the instruction after itself
   assign ret_pc = pc + 1'b1;

   ////////////////////
   // Next micro-PC

   always_comb begin
      case (ctl.pc_src)
         PC_JUMP: next_pc = target;
         PC_DISP: next_pc = disp_addr;
         PC_SPC:  next_pc = spc_top;
         PC_TRAP: next_pc = `USEQ_TRAP_ADDR;
         default: next_pc = ret_pc;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (ctl.fetch) begin
         pc <= next_pc;
      end
   end

endmodule

`default_nettype wire

// File: design/seq_control.sv
`timescale 1ns/10ps
`default_nettype none

module seq_control (
   input  wire                         clk,
   input  wire                         reset,
   input  wire useq_pkg::uinst_t       uinst,
   input  wire useq_pkg::disp_entry_t  disp,
   input  wire                         jcond,
   input  wire                         trap,
   output useq_pkg::seq_ctl_t          ctl,
   output logic                        spc_drive,
   output logic                        annul,
   output useq_pkg::phase_t            phase
);
   import useq_pkg::*;

   uinst_t      uinst_q;
   disp_entry_t disp_q;
   logic        jcond_q;
   logic        trap_q;
   logic        annul_q;
   logic        annulled;
   logic        taken;
   logic        next_n;
   pc_src_t     pc_src;
   logic        push;
   logic        pop;
   logic        push_ext;

   ////////////////////
   // Phase sequencing

   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= PH_DECODE;
      end else begin
         case (phase)
            PH_DECODE: phase <= PH_ALU;
            PH_ALU:    phase <= PH_WRITE;
            PH_WRITE:  phase <= PH_FETCH;
            default:   phase <= PH_DECODE;
         endcase
      end
   end

   // Instruction inputs held for the rest of the instruction
   always_ff @(posedge clk) begin
      if (reset) begin
         uinst_q <= '0;
         trap_q  <= 1'b0;
      end else if (phase == PH_DECODE) begin
         uinst_q <= uinst;
         trap_q  <= trap;
      end
   end

   always_ff @(posedge clk) begin
      if (phase == PH_DECODE) begin
         disp_q  <= disp;
         jcond_q <= jcond;
      end
   end

   // Annul bit for the following instruction, loaded at fetch
   always_ff @(posedge clk) begin
      if (reset) begin
         annul_q <= 1'b0;
      end else if (phase == PH_FETCH) begin
         annul_q <= next_n;
      end
   end

   ////////////////////
   // Next-PC and stack decision

   assign annulled = annul_q | trap_q;
   assign taken    = jcond_q ^ uinst_q.jump_false;

   always_comb begin
      pc_src   = PC_INC;
      push     = 1'b0;
      pop      = 1'b0;
      push_ext = 1'b0;
      next_n   = 1'b0;
      if (trap_q) begin
         pc_src = PC_TRAP;
      end else if (!annul_q) begin
         case (uinst_q.kind)
            UK_JUMP: begin
               if (taken) begin
                  next_n = uinst_q.jump_n;
                  if (uinst_q.jump_ret) begin
                     pop    = 1'b1;
                     pc_src = PC_SPC;
                  end else begin
                     push   = uinst_q.jump_call;
                     pc_src = PC_JUMP;
                  end
               end
            end
            UK_DISP: begin
               next_n = disp_q.n;
               // p and r together fall through to the increment
               if (disp_q.r && !disp_q.p) begin
                  pop    = 1'b1;
                  pc_src = PC_SPC;
               end else if (!disp_q.r) begin
                  push   = disp_q.p;
                  pc_src = PC_DISP;
               end
            end
            default: ;
         endcase
         if (uinst_q.popj) begin
            pop    = 1'b1;
            pc_src = PC_SPC;
         end
         if (uinst_q.src_spc_pop) begin
            pop = 1'b1;
         end
         // Bus write to the stack wins over a call push
         if (uinst_q.dest_spc) begin
            push     = 1'b1;
            push_ext = 1'b1;
         end
      end
   end

   always_comb begin
      ctl.pc_src    = pc_src;
      ctl.push      = push;
      ctl.pop       = pop;
      ctl.push_ext  = push_ext;
      ctl.write     = (phase == PH_WRITE);
      ctl.fetch     = (phase == PH_FETCH);
      ctl.target    = uinst_q.target;
      ctl.disp_addr = disp_q.addr;
   end

   assign annul     = annulled;
   assign spc_drive = !annulled && (uinst_q.src_spc || uinst_q.src_spc_pop) &&
                      (phase != PH_DECODE);

endmodule

`default_nettype wire

// File: design/spc_stack.sv
`timescale 1ns/10ps
`default_nettype none

`include "useq_settings.svh"

module spc_stack (
   input  wire                      clk,
   input  wire                      reset,
   input  wire useq_pkg::seq_ctl_t  ctl,
   input  wire useq_pkg::pc_t       ret_pc,
   input  wire useq_pkg::pc_t       spc_wdata,
   output useq_pkg::pc_t            spc_top,
   output useq_pkg::spc_ptr_t       spc_ptr
);
   import useq_pkg::*;

   pc_t      mem [`USEQ_SPC_DEPTH];
   pc_t      push_data;
   pc_t      live_top;
   pc_t      held_top;
   spc_ptr_t ptr_up;
   spc_ptr_t ptr_down;
   spc_ptr_t wr_ptr;

   // Pointer wraps modulo the depth, no overflow detection
   assign ptr_up   = spc_ptr + 1'b1;
   assign ptr_down = spc_ptr - 1'b1;

   assign push_data = ctl.push_ext ? spc_wdata : ret_pc;
   assign live_top  = mem[spc_ptr];

   // Push with pop overwrites the current top in place
   assign wr_ptr = ctl.pop ? spc_ptr : ptr_up;

   ////////////////////
   // Pointer update at the end of the write phase

   always_ff @(posedge clk) begin
      if (reset) begin
         spc_ptr <= '0;
      end else if (ctl.write) begin
         if (ctl.push && !ctl.pop) begin
            spc_ptr <= ptr_up;
         end else if (ctl.pop && !ctl.push) begin
            spc_ptr <= ptr_down;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctl.write) begin
         held_top <= live_top;
         if (ctl.push) begin
            mem[wr_ptr] <= push_data;
         end
      end
   end

   ////////////////////
   // During fetch the top from before the update is shown,
   // so a popj returns to the entry it popped
   assign spc_top = ctl.fetch ? held_top : live_top;

endmodule

`default_nettype wire

// File: design/useq_pkg.sv
`default_nettype none

`include "useq_settings.svh"

package useq_pkg;

   typedef logic [`USEQ_PC_WIDTH-1:0]       pc_t;
   typedef logic [`USEQ_SPC_DEPTH_LOG2-1:0] spc_ptr_t;

   // Four phases of one microinstruction
   typedef enum logic [1:0] {
      PH_DECODE = 2'd0,
      PH_ALU    = 2'd1,
      PH_WRITE  = 2'd2,
      PH_FETCH  = 2'd3
   } phase_t;

   // Where the next micro-PC comes from
   typedef enum logic [2:0] {
      PC_INC  = 3'd0,
      PC_JUMP = 3'd1,
      PC_DISP = 3'd2,
      PC_SPC  = 3'd3,
      PC_TRAP = 3'd4
   } pc_src_t;

   typedef enum logic [1:0] {
      UK_ALU  = 2'd0,
      UK_JUMP = 2'd1,
      UK_DISP = 2'd2
   } uinst_kind_t;

   ////////////////////
   // Microinstruction fields seen by the sequencer
   typedef struct packed {
      uinst_kind_t kind;
      logic        popj;
      logic        src_spc;
      logic        src_spc_pop;
      logic        dest_spc;
      logic        jump_false;
      logic        jump_n;
      logic        jump_call;
      logic        jump_ret;
      pc_t         target;
   } uinst_t;

   // Dispatch memory entry
   typedef struct packed {
      logic n;
      logic p;
      logic r;
      pc_t  addr;
   } disp_entry_t;

   ////////////////////
   // Control bundle from seq_control to the PC and stack units
   typedef struct packed {
      pc_src_t pc_src;
      logic    push;
      logic    pop;
      logic    push_ext;   // push spc_wdata rather than ret_pc
      logic    fetch;
      logic    write;
      pc_t     target;
      pc_t     disp_addr;
   } seq_ctl_t;

endpackage

`default_nettype wire

// File: useq_settings.svh
`ifndef USEQ_SETTINGS_SVH
`define USEQ_SETTINGS_SVH

// Micro-PC width, also the width of every return address
`define USEQ_PC_WIDTH 14

// Subroutine PC stack, 32 entries
`define USEQ_SPC_DEPTH_LOG2 5
`define USEQ_SPC_DEPTH (1 << `USEQ_SPC_DEPTH_LOG2)

// Vector taken when a trap annuls the current instruction
`define USEQ_TRAP_ADDR 14'h2000

`endif

// File: verif/microsequencer_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "useq_settings.svh"

module microsequencer_tb;
   import useq_pkg::*;

   // Instructions issued by all tests together
   localparam int NUM_INST    = 68;
   localparam int CYCLE_LIMIT = 4 * NUM_INST + 40;

   logic        clk;
   logic        reset;
   uinst_t      uinst;
   disp_entry_t disp;
   logic        jcond;
   logic        trap;
   pc_t         spc_wdata;
   pc_t         pc;
   logic        fetch;
   logic        annul;
   logic        spc_drive;
   pc_t         spc_data;
   spc_ptr_t    spc_ptr;

   // Reference model state
   pc_t         m_pc;
   pc_t         m_stack [`USEQ_SPC_DEPTH];
   spc_ptr_t    m_ptr;
   logic        m_annul;
   logic [31:0] lcg_state = 32'he6a4ecdb;
   int          cycle_count = 0;

   microsequencer uut (
      .clk       (clk),
      .reset     (reset),
      .uinst     (uinst),
      .disp      (disp),
      .jcond     (jcond),
      .trap      (trap),
      .spc_wdata (spc_wdata),
      .pc        (pc),
      .fetch     (fetch),
      .annul     (annul),
      .spc_drive (spc_drive),
      .spc_data  (spc_data),
      .spc_ptr   (spc_ptr)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT) begin
         fail_run("timeout: fetch never arrived");
      end
   end

   ////////////////////
   // Helpers

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_pc(input pc_t actual, input pc_t expected, input string what);
      if (actual !== expected) begin
         fail_run($sformatf("Error at %0t ns: %s is %h, expected %h",
                            $time, what, actual, expected));
      end
   endtask

   task automatic check_ptr(input spc_ptr_t actual, input spc_ptr_t expected,
                            input string what);
      if (actual !== expected) begin
         fail_run($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                            $time, what, actual, expected));
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         fail_run($sformatf("Error at %0t ns: %s is %b, expected %b",
                            $time, what, actual, expected));
      end
   endtask

   function automatic uinst_t alu_inst(input logic popj, input logic src,
                                       input logic src_pop, input logic dest);
      uinst_t ui;
      ui             = '0;
      ui.popj        = popj;
      ui.src_spc     = src;
      ui.src_spc_pop = src_pop;
      ui.dest_spc    = dest;
      return ui;
   endfunction

   function automatic uinst_t jump_inst(input pc_t target, input logic jf, input logic n,
                                        input logic call, input logic ret);
      uinst_t ui;
      ui            = '0;
      ui.kind       = UK_JUMP;
      ui.jump_false = jf;
      ui.jump_n     = n;
      ui.jump_call  = call;
      ui.jump_ret   = ret;
      ui.target     = target;
      return ui;
   endfunction

   ////////////////////
   // One instruction driven at the start of decode and checked against the model

   task automatic run_inst(input uinst_t ui, input disp_entry_t d, input logic jc,
                           input logic tr, input pc_t wd);
      pc_src_t src;
      logic    push;
      logic    pop;
      logic    nn;
      logic    cut;
      logic    drive;
      pc_t     top;
      pc_t     val;
      int      n;
      cut   = m_annul | tr;
      src   = PC_INC;
      push  = 1'b0;
      pop   = 1'b0;
      nn    = 1'b0;
      if (tr) begin
         src = PC_TRAP;
      end else if (!m_annul) begin
         if (ui.kind == UK_JUMP && (jc != ui.jump_false)) begin
            nn = ui.jump_n;
            if (ui.jump_ret) begin
               src = PC_SPC;
               pop = 1'b1;
            end else begin
               src  = PC_JUMP;
               push = ui.jump_call;
            end
         end
         if (ui.kind == UK_DISP) begin
            nn = d.n;
            if (d.r && !d.p) begin
               src = PC_SPC;
               pop = 1'b1;
            end else if (!d.r) begin
               src  = PC_DISP;
               push = d.p;
            end
         end
         if (ui.popj) begin
            src = PC_SPC;
            pop = 1'b1;
         end
         pop  = pop | ui.src_spc_pop;
         push = push | ui.dest_spc;
      end
      top   = m_stack[m_ptr];
      drive = !cut && (ui.src_spc || ui.src_spc_pop);
      val   = (!cut && ui.dest_spc) ? wd : m_pc + pc_t'(1);

      uinst     <= ui;
      disp      <= d;
      jcond     <= jc;
      trap      <= tr;
      spc_wdata <= wd;

      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n == 1) begin
            check_pc(pc, m_pc, "pc");
            check_flag(spc_drive, 1'b0, "spc_drive in decode");
         end else begin
            check_flag(annul, cut, "annul");
            check_flag(spc_drive, drive, "spc_drive");
            if (drive) begin
               check_pc(spc_data, top, "spc_data");
            end
         end
      end while (!fetch);
      check_flag(n == 4, 1'b1, "fetch in fourth cycle");

      // Push with pop replaces the top of the model stack
      if (push && pop) begin
         m_stack[m_ptr] = val;
      end else if (push) begin
         m_ptr          = m_ptr + spc_ptr_t'(1);
         m_stack[m_ptr] = val;
      end else if (pop) begin
         m_ptr = m_ptr - spc_ptr_t'(1);
      end
      check_ptr(spc_ptr, m_ptr, "spc_ptr");

      @(posedge clk);
      case (src)
         PC_JUMP: m_pc = ui.target;
         PC_DISP: m_pc = d.addr;
         PC_SPC:  m_pc = top;
         PC_TRAP: m_pc = `USEQ_TRAP_ADDR;
         default: m_pc = m_pc + pc_t'(1);
      endcase
      m_annul = nn;
   endtask

   task automatic run_alu(input uinst_t ui, input pc_t wd);
      run_inst(ui, '0, 1'b0, 1'b0, wd);
   endtask

   task automatic run_taken(input pc_t target, input logic n, input logic call,
                            input logic ret);
      run_inst(jump_inst(target, 1'b0, n, call, ret), '0, 1'b1, 1'b0, '0);
   endtask

   task automatic run_disp(input logic n, input logic p, input logic r, input pc_t addr);
      uinst_t      ui;
      disp_entry_t d;
      ui      = '0;
      ui.kind = UK_DISP;
      d.n     = n;
      d.p     = p;
      d.r     = r;
      d.addr  = addr;
      run_inst(ui, d, 1'b0, 1'b0, '0);
   endtask

   ////////////////////
   // Directed tests

   task automatic reset_and_sequence();
      repeat (3) run_alu(alu_inst(1'b0, 1'b0, 1'b0, 1'b0), '0);
   endtask

   task automatic cond_jumps();
      logic [31:0] r;
      repeat (8) begin
         r = rand_next();
         run_inst(jump_inst(pc_t'(r), r[30], 1'b0, 1'b0, 1'b0), '0, r[31], 1'b0, '0);
      end
      // Taken jump with n set annuls the call after it
      run_taken(pc_t'(rand_next()), 1'b1, 1'b0, 1'b0);
      run_taken(pc_t'(rand_next()), 1'b0, 1'b1, 1'b0);
      run_alu(alu_inst(1'b0, 1'b0, 1'b0, 1'b0), '0);
   endtask

   task automatic calls_and_returns();
      repeat (3) run_taken(pc_t'(rand_next()), 1'b0, 1'b1, 1'b0);
      run_taken('0, 1'b0, 1'b0, 1'b1);
      run_alu(alu_inst(1'b1, 1'b0, 1'b0, 1'b0), '0);
      run_taken('0, 1'b0, 1'b0, 1'b1);
      // 33 pushes from an empty stack leave the pointer at 1
      repeat (33) run_taken(pc_t'(rand_next()), 1'b0, 1'b1, 1'b0);
      check_ptr(spc_ptr, spc_ptr_t'(1), "spc_ptr after wrap");
   endtask

   task automatic dispatch_cases();
      run_disp(1'b0, 1'b1, 1'b0, pc_t'(rand_next()));
      run_disp(1'b0, 1'b0, 1'b1, pc_t'(rand_next()));
      run_disp(1'b0, 1'b1, 1'b1, pc_t'(rand_next()));
      run_disp(1'b0, 1'b0, 1'b0, pc_t'(rand_next()));
      run_disp(1'b1, 1'b0, 1'b0, pc_t'(rand_next()));
      run_disp(1'b0, 1'b1, 1'b0, pc_t'(rand_next()));
      run_alu(alu_inst(1'b0, 1'b0, 1'b0, 1'b0), '0);
   endtask

   task automatic spc_bus_access();
      run_alu(alu_inst(1'b0, 1'b0, 1'b0, 1'b1), pc_t'(rand_next()));
      run_alu(alu_inst(1'b0, 1'b1, 1'b0, 1'b0), '0);
      run_alu(alu_inst(1'b0, 1'b0, 1'b1, 1'b0), '0);
      run_alu(alu_inst(1'b0, 1'b0, 1'b0, 1'b1), pc_t'(rand_next()));
      run_alu(alu_inst(1'b1, 1'b0, 1'b0, 1'b1), pc_t'(rand_next()));
      // Read back the top written by popj with dest_spc
      run_alu(alu_inst(1'b0, 1'b1, 1'b0, 1'b0), '0);
   endtask

   task automatic trap_entry();
      uinst_t ui;
      ui         = jump_inst(pc_t'(rand_next()), 1'b0, 1'b0, 1'b1, 1'b0);
      ui.src_spc = 1'b1;
      run_inst(ui, '0, 1'b1, 1'b1, '0);
      run_alu(alu_inst(1'b0, 1'b0, 1'b0, 1'b0), '0);
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      uinst     = '0;
      disp      = '0;
      jcond     = 1'b0;
      trap      = 1'b0;
      spc_wdata = '0;
      m_pc      = '0;
      m_ptr     = '0;
      m_annul   = 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      reset_and_sequence();
      cond_jumps();
      calls_and_returns();
      dispatch_cases();
      spc_bus_access();
      trap_entry();
      @(negedge clk);
      check_pc(pc, m_pc, "pc after last instruction");
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
design/useq_pkg.sv
design/seq_control.sv
design/pc_select.sv
design/spc_stack.sv
design/microsequencer.sv
verif/microsequencer_tb.sv
